// File: design/icache_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared sizes and types of the instruction cache.
// Direct mapped with one 32-bit word per line.
// A tag word is the word address with TAG_VALID in bits 1:0,
// so an all-zero line never matches.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package icache_pkg;

	// Index taken from pc bits 2 and up.
	localparam int ICACHE_INDEX_BITS = 6;
	localparam int ICACHE_LINES = 1 << ICACHE_INDEX_BITS;

	// Marker in the low bits of a tag word.
	localparam logic [1:0] TAG_VALID = 2'b01;

	// Instruction word or byte address.
	typedef logic [31:0] word_t;

	typedef logic [ICACHE_INDEX_BITS-1:0] index_t;

	// Instruction word in 63:32, tag word in 31:0.
	typedef logic [63:0] line_t;

	typedef logic [31:0] count_t;

	// Controller states.
	typedef enum logic [1:0] {
		CLEAR   = 2'd0,
		ADDRESS = 2'd1,
		LOOKUP  = 2'd2,
		FILL    = 2'd3
	} ctrl_state_t;

endpackage

// File: design/icache_port_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single port of the cache RAM.
// An access happens every cycle, rdata lags the index by one.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
interface icache_port_if;
	import icache_pkg::*;

	logic rw;
	index_t index;
	line_t wdata;
	line_t rdata;

	// Controller side.
	modport owner (output rw, output index, output wdata);

	modport memory (input rw, input index, input wdata, output rdata);

	// Read-only view for the tag compare.
	modport monitor (input rdata);

endinterface

// File: design/icache_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One-port line RAM with a registered read.
// Read during write returns the old line.
// Contents are undefined until the controller clears them.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module icache_ram (
	input logic i_clock,
	icache_port_if.memory port
);
	import icache_pkg::*;

	line_t lines [ICACHE_LINES];

	// Write first in the array, but the read register sees the old value.
	always_ff @(posedge i_clock) begin
		if (port.rw) begin
			lines[port.index] <= port.wdata;
		end
		port.rdata <= lines[port.index];
	end

endmodule

// File: design/icache_lookup.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tag compare of the current pc against the RAM output.
// Purely combinational.
// A hit is only valid when the RAM output belongs to i_pc.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module icache_lookup (
	input icache_pkg::word_t i_pc,
	input icache_pkg::word_t i_read_pc,
	icache_port_if.monitor port,
	output logic o_hit,
	output logic o_stale,
	output icache_pkg::word_t o_hit_word,
	output icache_pkg::word_t o_fill_tag
);
	import icache_pkg::*;

	word_t fill_tag;
	word_t line_tag;
	logic tag_match;

	// Word address with the valid marker below it.
	assign fill_tag = {i_pc[31:2], TAG_VALID};

	assign line_tag = port.rdata[31:0];
	assign tag_match = (line_tag == fill_tag);

	// RAM shows the line of another pc after a jump.
	assign o_stale = (i_pc != i_read_pc);

	assign o_hit = !o_stale && tag_match;

	assign o_hit_word = port.rdata[63:32];

	// Same tag is written back on a fill.
	assign o_fill_tag = fill_tag;

endmodule

// File: design/icache_control.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cache controller and owner of the RAM port.
// Clears all lines after reset before serving fetches.
// i_pc must stay stable until the word is taken.
// A bus ready seen together with the miss is taken at once.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module icache_control (
	input logic i_clock,
	input logic i_reset,
	input icache_pkg::word_t i_pc,
	input logic i_hit,
	input logic i_stale,
	input icache_pkg::word_t i_fill_tag,
	input logic i_bus_ready,
	input icache_pkg::word_t i_bus_rdata,
	icache_port_if.owner port,
	output icache_pkg::word_t o_read_pc,
	output logic o_bus_request,
	output logic o_hit_take,
	output logic o_fill_take
);
	import icache_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_next;
	index_t clear_index;
	word_t read_pc;
	word_t read_pc_next;
	word_t pc_ahead;
	logic miss;
	logic fill_active;

	assign pc_ahead = i_pc + 32'd4;

	assign miss = (state == LOOKUP) && !i_stale && !i_hit;

	// Request holds from the miss until the bus answers.
	assign fill_active = miss || (state == FILL);
	assign o_bus_request = fill_active;

	assign o_fill_take = fill_active && i_bus_ready;
	assign o_hit_take = (state == LOOKUP) && i_hit;

	assign o_read_pc = read_pc;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= CLEAR;
			clear_index <= '0;
			read_pc <= '0;
		end else begin
			state <= state_next;
			read_pc <= read_pc_next;
			if (state == CLEAR) begin
				clear_index <= clear_index + 1'b1;
			end
		end
	end

	always_comb begin
		state_next = state;
		read_pc_next = read_pc;
		port.rw = 1'b0;
		port.index = i_pc[ICACHE_INDEX_BITS+1:2];
		port.wdata = '0;

		case (state)
			CLEAR: begin
				// One zero line per cycle.
				port.rw = 1'b1;
				port.index = clear_index;
				if (clear_index == index_t'(ICACHE_LINES - 1)) begin
					state_next = ADDRESS;
				end
			end

			ADDRESS: begin
				read_pc_next = i_pc;
				state_next = LOOKUP;
			end

			LOOKUP: begin
				if (i_stale) begin
					state_next = ADDRESS;
				end else if (i_hit) begin
					// Read ahead for a sequential stream.
					port.index = pc_ahead[ICACHE_INDEX_BITS+1:2];
					read_pc_next = pc_ahead;
				end else begin
					state_next = FILL;
				end
			end

			FILL: begin
				// Wait for the bus.
			end

			default: begin
				state_next = CLEAR;
			end
		endcase

		// Bus word goes into the line of i_pc.
		if (o_fill_take) begin
			port.rw = 1'b1;
			port.wdata = {i_bus_rdata, i_fill_tag};
			state_next = ADDRESS;
		end
	end

endmodule

// File: design/icache_response.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch response and statistics.
// o_ready is a one-cycle pulse, o_instr is zero otherwise.
// Counters wrap and clear only on reset.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module icache_response (
	input logic i_clock,
	input logic i_reset,
	input logic i_hit_take,
	input logic i_fill_take,
	input icache_pkg::word_t i_hit_word,
	input icache_pkg::word_t i_bus_rdata,
	output logic o_ready,
	output icache_pkg::word_t o_instr,
	output icache_pkg::count_t o_hit_count,
	output icache_pkg::count_t o_fill_count
);

	assign o_ready = i_hit_take || i_fill_take;

	// Bus word wins on a fill.
	always_comb begin
		if (i_fill_take) begin
			o_instr = i_bus_rdata;
		end else if (i_hit_take) begin
			o_instr = i_hit_word;
		end else begin
			o_instr = '0;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_hit_count <= '0;
			o_fill_count <= '0;
		end else begin
			if (i_hit_take) begin
				o_hit_count <= o_hit_count + 1'b1;
			end
			if (i_fill_take) begin
				o_fill_count <= o_fill_count + 1'b1;
			end
		end
	end

endmodule

// File: design/icache_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Direct-mapped instruction cache for the fetch stage.
// pc must be word aligned and held until o_ready.
// Bus address follows i_pc for the whole request.
// No fetches are served during the clear after reset.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module icache_top (
	input logic i_clock,
	input logic i_reset,
	input icache_pkg::word_t i_pc,
	output icache_pkg::word_t o_instr,
	output logic o_ready,
	output logic o_bus_request,
	input logic i_bus_ready,
	output icache_pkg::word_t o_bus_address,
	input icache_pkg::word_t i_bus_rdata,
	output icache_pkg::count_t o_hit_count,
	output icache_pkg::count_t o_fill_count
);
	import icache_pkg::*;

	word_t read_pc;
	word_t hit_word;
	word_t fill_tag;
	logic hit;
	logic stale;
	logic hit_take;
	logic fill_take;

	icache_port_if port ();

	assign o_bus_address = i_pc;

	icache_ram ram (
		.i_clock(i_clock),
		.port(port.memory)
	);

	icache_lookup lookup (
		.i_pc(i_pc),
		.i_read_pc(read_pc),
		.port(port.monitor),
		.o_hit(hit),
		.o_stale(stale),
		.o_hit_word(hit_word),
		.o_fill_tag(fill_tag)
	);

	icache_control control (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_pc(i_pc),
		.i_hit(hit),
		.i_stale(stale),
		.i_fill_tag(fill_tag),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata),
		.port(port.owner),
		.o_read_pc(read_pc),
		.o_bus_request(o_bus_request),
		.o_hit_take(hit_take),
		.o_fill_take(fill_take)
	);

	icache_response response (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_hit_take(hit_take),
		.i_fill_take(fill_take),
		.i_hit_word(hit_word),
		.i_bus_rdata(i_bus_rdata),
		.o_ready(o_ready),
		.o_instr(o_instr),
		.o_hit_count(o_hit_count),
		.o_fill_count(o_fill_count)
	);

endmodule

// File: verif/icache_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the instruction cache.
// Bus memory returns the address XOR a fixed pattern
// after 0 to 3 request cycles.
// A tag model predicts hit or fill for every fetch.
// The run stops at the first mismatch.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module icache_tb;
	timeunit 1ns;
	timeprecision 1ns;
	import icache_pkg::*;

	localparam int HALF_PERIOD = 50;
	localparam int RESET_CYCLES = 3;
	localparam int MAX_FETCH_CYCLES = 12;
	localparam int FETCH_COUNT = 42;
	localparam int RESET_COUNT = 2;
	localparam int RUN_WORDS = 16;
	localparam word_t BUS_PATTERN = 32'h5a3c_96e1;
	localparam word_t RUN_BASE = 32'h0000_0040;
	localparam word_t JUMP_BACK_PC = 32'h0000_0048;
	localparam word_t JUMP_NEW_PC = 32'h0000_2000;
	// Same index 32, different tags.
	localparam word_t ALIAS_A = 32'h0000_0180;
	localparam word_t ALIAS_B = 32'h0000_1180;

	logic i_clock;
	logic i_reset;
	word_t i_pc;
	word_t o_instr;
	logic o_ready;
	logic o_bus_request;
	logic i_bus_ready;
	word_t o_bus_address;
	word_t i_bus_rdata;
	count_t o_hit_count;
	count_t o_fill_count;

	integer seed = 32'hbc10_326f;
	logic [29:0] tag_model [ICACHE_LINES];
	logic tag_valid [ICACHE_LINES];

	icache_top dut (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_pc(i_pc),
		.o_instr(o_instr),
		.o_ready(o_ready),
		.o_bus_request(o_bus_request),
		.i_bus_ready(i_bus_ready),
		.o_bus_address(o_bus_address),
		.i_bus_rdata(i_bus_rdata),
		.o_hit_count(o_hit_count),
		.o_fill_count(o_fill_count)
	);

	always #HALF_PERIOD i_clock = ~i_clock;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic compare(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			abort_run($sformatf("error: %s is %h, expected %h", name, actual, expected));
		end
	endtask

	function automatic word_t bus_word(input word_t address);
		return address ^ BUS_PATTERN;
	endfunction

	function automatic index_t line_of(input word_t pc);
		return pc[ICACHE_INDEX_BITS+1:2];
	endfunction

	// Holds pc during reset so the cache starts on a stable fetch.
	task automatic apply_reset(input word_t pc);
		@(negedge i_clock);
		i_reset = 1'b1;
		i_pc = pc;
		i_bus_ready = 1'b0;
		repeat (RESET_CYCLES) @(negedge i_clock);
		i_reset = 1'b0;
		for (int i = 0; i < ICACHE_LINES; i++) begin
			tag_valid[i] = 1'b0;
		end
		// Silent while the lines are cleared.
		for (int k = 0; k < ICACHE_LINES; k++) begin
			#10;
			compare("o_ready", o_ready, 1'b0);
			compare("o_bus_request", o_bus_request, 1'b0);
			compare("o_hit_count", o_hit_count, 0);
			compare("o_fill_count", o_fill_count, 0);
			@(negedge i_clock);
		end
	endtask

	// Latency counts sampled cycles up to and including the ready one.
	task automatic fetch(input word_t pc, output int latency);
		index_t index;
		logic expect_fill;
		logic requested;
		int delay;
		int waited;
		index = line_of(pc);
		expect_fill = !(tag_valid[index] && tag_model[index] == pc[31:2]);
		delay = $unsigned($random(seed)) % 4;
		waited = 0;
		requested = 1'b0;
		latency = 1;
		@(negedge i_clock);
		i_pc = pc;
		i_bus_ready = 1'b0;
		#10;
		while (!o_ready) begin
			requested = requested | o_bus_request;
			// No word is shown before ready.
			compare("o_instr", o_instr, 32'h0);
			if (o_bus_request) begin
				compare("o_bus_address", o_bus_address, pc);
			end
			if (latency == MAX_FETCH_CYCLES) begin
				abort_run($sformatf("Fetch of pc %h never got ready.", pc));
			end
			@(negedge i_clock);
			// Bus answers after the drawn number of request cycles.
			if (o_bus_request && waited == delay) begin
				i_bus_ready = 1'b1;
				i_bus_rdata = bus_word(o_bus_address);
			end else begin
				if (o_bus_request) begin
					waited++;
				end
				i_bus_ready = 1'b0;
			end
			latency++;
			#10;
		end
		requested = requested | o_bus_request;
		if (o_bus_request) begin
			compare("o_bus_address", o_bus_address, pc);
		end
		compare("o_instr", o_instr, bus_word(pc));
		compare("bus request", requested, expect_fill);
		if (expect_fill) begin
			tag_model[index] = pc[31:2];
			tag_valid[index] = 1'b1;
		end
		// Counters have taken this fetch after the edge.
		@(posedge i_clock);
		#1;
	endtask

	task automatic first_fetch_after_reset();
		int latency;
		apply_reset(32'h0000_0000);
		fetch(32'h0000_0000, latency);
		compare("o_fill_count", o_fill_count, 1);
		compare("o_hit_count", o_hit_count, 0);
	endtask

	task automatic cold_sequential_run();
		int latency;
		count_t fills_before;
		fills_before = o_fill_count;
		for (int i = 0; i < RUN_WORDS; i++) begin
			fetch(word_t'(RUN_BASE + 4 * i), latency);
		end
		compare("o_fill_count increase", o_fill_count - fills_before, RUN_WORDS);
	endtask

	task automatic warm_sequential_run();
		int latency;
		count_t hits_before;
		count_t fills_before;
		hits_before = o_hit_count;
		fills_before = o_fill_count;
		for (int i = 0; i < RUN_WORDS; i++) begin
			fetch(word_t'(RUN_BASE + 4 * i), latency);
			// Read ahead gives one word per cycle.
			if (i > 0) begin
				compare("hit latency", latency, 1);
			end
		end
		compare("o_hit_count increase", o_hit_count - hits_before, RUN_WORDS);
		compare("o_fill_count increase", o_fill_count - fills_before, 0);
	endtask

	task automatic jump_fetches();
		int latency;
		count_t hits_before;
		count_t fills_before;
		hits_before = o_hit_count;
		fills_before = o_fill_count;
		fetch(JUMP_BACK_PC, latency);
		// New code lands on index 0 and evicts pc 0.
		fetch(JUMP_NEW_PC, latency);
		fetch(32'h0000_0000, latency);
		compare("o_hit_count increase", o_hit_count - hits_before, 1);
		compare("o_fill_count increase", o_fill_count - fills_before, 2);
	endtask

	task automatic evict_pair();
		int latency;
		count_t fills_before;
		fills_before = o_fill_count;
		repeat (2) begin
			fetch(ALIAS_A, latency);
			fetch(ALIAS_B, latency);
		end
		compare("o_fill_count increase", o_fill_count - fills_before, 4);
	endtask

	task automatic reset_mid_run();
		int latency;
		count_t hits_before;
		hits_before = o_hit_count;
		fetch(JUMP_BACK_PC, latency);
		compare("o_hit_count increase", o_hit_count - hits_before, 1);
		apply_reset(JUMP_BACK_PC);
		fetch(JUMP_BACK_PC, latency);
		compare("o_fill_count", o_fill_count, 1);
		compare("o_hit_count", o_hit_count, 0);
	endtask

	// Worst case for every fetch plus the clear after each reset.
	initial begin
		#((FETCH_COUNT * MAX_FETCH_CYCLES + RESET_COUNT * (RESET_CYCLES + ICACHE_LINES + 1)
			+ 20) * 2 * HALF_PERIOD);
		abort_run("Timeout: the tests did not finish in the expected time.");
	end

	initial begin
		i_clock = 1'b0;
		i_reset = 1'b1;
		i_pc = '0;
		i_bus_ready = 1'b0;
		i_bus_rdata = '0;
		first_fetch_after_reset();
		cold_sequential_run();
		warm_sequential_run();
		jump_fetches();
		evict_pair();
		reset_mid_run();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: icache_top.f
design/icache_pkg.sv
design/icache_port_if.sv
design/icache_ram.sv
design/icache_lookup.sv
design/icache_control.sv
design/icache_response.sv
design/icache_top.sv
verif/icache_tb.sv

// File: Bender.yml
package:
  name: icache
  description: "Direct-mapped instruction cache for a RISC-V fetch stage"

sources:
  - design/icache_pkg.sv
  - design/icache_port_if.sv
  - design/icache_ram.sv
  - design/icache_lookup.sv
  - design/icache_control.sv
  - design/icache_response.sv
  - design/icache_top.sv
  - target: simulation
    files:
      - verif/icache_tb.sv
